// File: src.f
logic/rv_pkg.sv
logic/rv_regfile.sv
logic/rv_decode.sv
logic/rv_stage_reg.sv
logic/rv_alu.sv
logic/rv_retire.sv
logic/rv_core_top.sv
bench/rv_core_asserts.sv
bench/rv_core_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := rv_core_tb
FILELIST  := src.f
PASS_MSG  := all tests passed

.PHONY: sim clean

# Build and run, status comes from grep finding the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: bench/rv_core_tb.sv
// Testbench for the RV32I subset core
// Random instruction stream with hazards and back-pressure, checked
// against an in-order register model of the ISA subset
`timescale 1ns/1ps

module rv_core_tb;

  localparam int NUM_INSTS      = 400;
  localparam int SEED           = 87330;
  localparam int TIMEOUT_CYCLES = NUM_INSTS * 8 + 50;

  logic            clk_i;
  logic            reset_i;
  logic            inst_valid_i;
  logic [31:0]     inst_i;
  logic            inst_ready_o;
  logic            result_valid_o;
  rv_pkg::retire_t result_o;
  logic            result_ready_i;

  // Architectural state of the model, x0 never written
  logic [rv_pkg::XLEN-1:0] model_regs [rv_pkg::NUM_REGS];
  // Expected records in acceptance order
  rv_pkg::retire_t         exp_q [$];
  int                      errors;
  int                      issued;
  int                      accepted;
  int                      retired;

  rv_core_top dut0 (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .inst_valid_i   (inst_valid_i),
    .inst_i         (inst_i),
    .inst_ready_o   (inst_ready_o),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .result_ready_i (result_ready_i)
  );

  bind rv_core_top rv_core_asserts asserts0 (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .inst_ready_o   (inst_ready_o),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .result_ready_i (result_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Mostly x0..x3 so that back-to-back dependencies are common
  function automatic logic [4:0] pick_reg();
    if ($urandom_range(99, 0) < 75) begin
      return 5'($urandom_range(3, 0));
    end
    return 5'($urandom_range(31, 0));
  endfunction

  function automatic logic [31:0] gen_inst();
    logic [31:0] w;
    logic [2:0]  f3;
    logic [6:0]  f7;
    int          kind;
    kind = $urandom_range(99, 0);
    if (kind < 8) begin
      // Arbitrary word, nearly always outside the subset
      w = $urandom();
    end else if (kind < 54) begin
      f3 = 3'($urandom_range(7, 0));
      f7 = (f3 == 3'b000 && $urandom_range(1, 0) == 1) ? 7'b0100000 : 7'b0000000;
      // Rare bad funct7
      if ($urandom_range(99, 0) < 4) begin
        f7 = 7'($urandom_range(127, 0));
      end
      w = {f7, pick_reg(), pick_reg(), f3, pick_reg(), rv_pkg::OPC_OP};
    end else begin
      case ($urandom_range(9, 0))
        0:       f3 = 3'($urandom_range(7, 0));
        1, 2:    f3 = 3'b000;
        3, 4:    f3 = 3'b010;
        5, 6:    f3 = 3'b100;
        7:       f3 = 3'b110;
        default: f3 = 3'b111;
      endcase
      w = {12'($urandom()), pick_reg(), f3, pick_reg(), rv_pkg::OPC_OP_IMM};
    end
    return w;
  endfunction

  // Executes one word on the model and returns its retire record
  task automatic model_exec(input logic [31:0] w, output rv_pkg::retire_t rec);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] v;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        ill;
    rd  = w[11:7];
    f3  = w[14:12];
    f7  = w[31:25];
    a   = model_regs[w[19:15]];
    b   = '0;
    v   = '0;
    ill = 1'b0;
    if (w[6:0] == rv_pkg::OPC_OP) begin
      b = model_regs[w[24:20]];
      if (f7 == 7'b0100000 && f3 == 3'b000) begin
        v = a - b;
      end else if (f7 != 7'b0000000) begin
        ill = 1'b1;
      end else begin
        case (f3)
          3'b000:  v = a + b;
          3'b001:  v = a << b[4:0];
          3'b010:  v = {31'b0, $signed(a) < $signed(b)};
          3'b100:  v = a ^ b;
          3'b101:  v = a >> b[4:0];
          3'b110:  v = a | b;
          3'b111:  v = a & b;
          // SLTU is not in the subset
          default: ill = 1'b1;
        endcase
      end
    end else if (w[6:0] == rv_pkg::OPC_OP_IMM) begin
      b = {{20{w[31]}}, w[31:20]};
      case (f3)
        3'b000:  v = a + b;
        3'b010:  v = {31'b0, $signed(a) < $signed(b)};
        3'b100:  v = a ^ b;
        3'b110:  v = a | b;
        3'b111:  v = a & b;
        default: ill = 1'b1;
      endcase
    end else begin
      ill = 1'b1;
    end
    if (ill) begin
      v = '0;
    end else if (rd != 5'd0) begin
      model_regs[rd] = v;
    end
    rec.rd      = rd;
    rec.value   = v;
    rec.illegal = ill;
  endtask

  // Stimulus, sampling at the falling edge and checks
  initial begin
    rv_pkg::retire_t rec;
    rv_pkg::retire_t held_rec;
    logic            held;
    logic            in_hs;
    logic            out_hs;
    void'($urandom(SEED));
    for (int r = 0; r < rv_pkg::NUM_REGS; r++) begin
      model_regs[r] = '0;
    end
    errors         = 0;
    issued         = 0;
    accepted       = 0;
    retired        = 0;
    held           = 1'b0;
    held_rec       = '0;
    in_hs          = 1'b0;
    reset_i        = 1'b1;
    inst_valid_i   = 1'b0;
    inst_i         = '0;
    result_ready_i = 1'b0;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    if (result_valid_o || !inst_ready_o) begin
      errors++;
      $display("Error at %0t: after reset valid %b ready %b", $time,
               result_valid_o, inst_ready_o);
    end
    while (retired < NUM_INSTS) begin
      @(posedge clk_i);
      result_ready_i <= ($urandom_range(1, 0) == 1);
      // A presented word stays until it is taken
      if (!inst_valid_i || in_hs) begin
        if (issued < NUM_INSTS && $urandom_range(99, 0) < 80) begin
          inst_valid_i <= 1'b1;
          inst_i       <= gen_inst();
          issued++;
        end else begin
          inst_valid_i <= 1'b0;
        end
      end
      @(negedge clk_i);
      in_hs  = inst_valid_i && inst_ready_o;
      out_hs = result_valid_o && result_ready_i;
      if (held && (!result_valid_o || result_o !== held_rec)) begin
        errors++;
        $display("Error at %0t: stalled result changed or dropped", $time);
      end
      held     = result_valid_o && !result_ready_i;
      held_rec = result_o;
      if (out_hs) begin
        retired++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Result retired at %0t with no accepted instruction outstanding", $time);
        end else begin
          rec = exp_q.pop_front();
          if (result_o !== rec) begin
            errors++;
            $display("Error at %0t: result %0d rd %0d val %h ill %b, exp rd %0d val %h ill %b",
                     $time, retired, result_o.rd, result_o.value, result_o.illegal,
                     rec.rd, rec.value, rec.illegal);
          end
        end
      end
      if (in_hs) begin
        model_exec(inst_i, rec);
        exp_q.push_back(rec);
        accepted++;
      end
    end
    // Drained pipeline must stay quiet
    @(posedge clk_i);
    result_ready_i <= 1'b1;
    repeat (4) begin
      @(negedge clk_i);
      if (result_valid_o) begin
        errors++;
        $display("Extra result presented at %0t after all instructions retired", $time);
      end
    end
    if (accepted != NUM_INSTS || exp_q.size() != 0) begin
      errors++;
      $display("Retire count mismatch: %0d accepted, %0d retired", accepted, retired);
    end
    $display("Run complete: %0d accepted, %0d retired, %0d errors", accepted, retired, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Cycle limit
  initial begin
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: run stopped after %0d cycles with %0d of %0d results retired",
             cycles, retired, NUM_INSTS);
    $display("tests failed");
    $finish;
  end

endmodule

// File: bench/rv_core_asserts.sv
// Protocol assertions for the core top level
// Reset state and output hold under back-pressure
`timescale 1ns/1ps

module rv_core_asserts (
  input logic            clk_i,
  input logic            reset_i,
  input logic            inst_ready_o,
  input logic            result_valid_o,
  input rv_pkg::retire_t result_o,
  input logic            result_ready_i
);

  // Decode takes instructions on the first cycle out of reset
  ready_after_reset: assert property (@(posedge clk_i) $fell(reset_i) |-> inst_ready_o)
    else $error("inst_ready_o low on the first cycle after reset");

  // Nothing retires while reset is applied
  idle_in_reset: assert property (@(posedge clk_i) reset_i |=> !result_valid_o)
    else $error("result_valid_o high following a reset cycle");

  // Stalled result record must hold
  result_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    result_valid_o && !result_ready_i |=> result_valid_o && $stable(result_o))
    else $error("result changed or dropped while result_ready_i was low");

endmodule

// File: logic/rv_core_top.sv
// RV32I subset core
// Decode, issue register, ALU, execute register and retire around the register file
`timescale 1ns/1ps

module rv_core_top (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            inst_valid_i,
  input  logic [31:0]     inst_i,
  output logic            inst_ready_o,
  output logic            result_valid_o,
  output rv_pkg::retire_t result_o,
  input  logic            result_ready_i
);

  // Register file ports
  logic [rv_pkg::REG_ADDR_W-1:0] raddr_a;
  logic [rv_pkg::REG_ADDR_W-1:0] raddr_b;
  logic [rv_pkg::XLEN-1:0]       rdata_a;
  logic [rv_pkg::XLEN-1:0]       rdata_b;
  logic [rv_pkg::REG_ADDR_W-1:0] waddr;
  logic [rv_pkg::XLEN-1:0]       wdata;
  logic                          we;

  // Decode to issue_q
  logic                          dec_valid;
  rv_pkg::issue_t                dec_issue;
  logic                          dec_ready;

  // issue_q through the ALU to exec_q, valid and ready bypass the ALU
  logic                          iss_valid;
  rv_pkg::issue_t                iss_data;
  logic                          iss_ready;
  rv_pkg::exec_t                 alu_result;

  // exec_q to retire
  logic                          ex_valid;
  rv_pkg::exec_t                 ex_data;
  logic                          ex_ready;

  // Scoreboard release
  logic                          free_valid;
  logic [rv_pkg::REG_ADDR_W-1:0] free_addr;

  rv_decode u_decode (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .inst_valid_i  (inst_valid_i),
    .inst_i        (inst_i),
    .inst_ready_o  (inst_ready_o),
    .raddr_a_o     (raddr_a),
    .raddr_b_o     (raddr_b),
    .rdata_a_i     (rdata_a),
    .rdata_b_i     (rdata_b),
    .issue_valid_o (dec_valid),
    .issue_o       (dec_issue),
    .issue_ready_i (dec_ready),
    .free_valid_i  (free_valid),
    .free_addr_i   (free_addr)
  );

  rv_regfile u_regfile (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .raddr_a_i (raddr_a),
    .rdata_a_o (rdata_a),
    .raddr_b_i (raddr_b),
    .rdata_b_o (rdata_b),
    .waddr_i   (waddr),
    .wdata_i   (wdata),
    .we_i      (we)
  );

  rv_stage_reg #(
    .payload_t (rv_pkg::issue_t)
  ) issue_q (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_valid_i  (dec_valid),
    .in_data_i   (dec_issue),
    .in_ready_o  (dec_ready),
    .out_valid_o (iss_valid),
    .out_data_o  (iss_data),
    .out_ready_i (iss_ready)
  );

  rv_alu u_alu (
    .issue_i  (iss_data),
    .result_o (alu_result)
  );

  rv_stage_reg #(
    .payload_t (rv_pkg::exec_t)
  ) exec_q (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_valid_i  (iss_valid),
    .in_data_i   (alu_result),
    .in_ready_o  (iss_ready),
    .out_valid_o (ex_valid),
    .out_data_o  (ex_data),
    .out_ready_i (ex_ready)
  );

  rv_retire u_retire (
    .exec_valid_i   (ex_valid),
    .exec_i         (ex_data),
    .exec_ready_o   (ex_ready),
    .waddr_o        (waddr),
    .wdata_o        (wdata),
    .we_o           (we),
    .free_valid_o   (free_valid),
    .free_addr_o    (free_addr),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .result_ready_i (result_ready_i)
  );

endmodule

// File: logic/rv_retire.sv
// Retire stage
// Turns the output handshake into the register write and scoreboard release
`timescale 1ns/1ps

module rv_retire (
  // From exec_q
  input  logic                          exec_valid_i,
  input  rv_pkg::exec_t                 exec_i,
  output logic                          exec_ready_o,

  // Register file write port
  output logic [rv_pkg::REG_ADDR_W-1:0] waddr_o,
  output logic [rv_pkg::XLEN-1:0]       wdata_o,
  output logic                          we_o,

  // Scoreboard release toward decode
  output logic                          free_valid_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] free_addr_o,

  // Retired-result stream
  output logic                          result_valid_o,
  output rv_pkg::retire_t               result_o,
  input  logic                          result_ready_i
);

  logic retire_hs;
  // Only legal ops with a real destination commit
  logic commit;

  assign result_valid_o = exec_valid_i;
  assign exec_ready_o   = result_ready_i;
  assign retire_hs      = exec_valid_i && result_ready_i;
  assign commit         = retire_hs && !exec_i.illegal && (exec_i.rd != '0);

  assign result_o.rd      = exec_i.rd;
  assign result_o.value   = exec_i.value;
  assign result_o.illegal = exec_i.illegal;

  // Write lands on the handshake edge
  assign waddr_o = exec_i.rd;
  assign wdata_o = exec_i.value;
  assign we_o    = commit;

  // Busy bit cleared on the same edge as the write
  assign free_valid_o = commit;
  assign free_addr_o  = exec_i.rd;

endmodule

// File: logic/rv_alu.sv
// Integer ALU for the execute stage
// Computes the result of one issued op, purely combinational
`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::issue_t issue_i,
  output rv_pkg::exec_t  result_o
);

  logic [rv_pkg::XLEN-1:0] op_a;
  logic [rv_pkg::XLEN-1:0] op_b;
  logic [rv_pkg::XLEN-1:0] res;
  logic [4:0]              shamt;
  logic                    lt_signed;

  assign op_a  = issue_i.op_a;
  assign op_b  = issue_i.op_b;
  // Shift amount from the low 5 bits of operand b
  assign shamt = op_b[4:0];

  assign lt_signed = $signed(op_a) < $signed(op_b);

  always_comb begin
    case (issue_i.alu_op)
      rv_pkg::ALU_ADD: res = op_a + op_b;
      rv_pkg::ALU_SUB: res = op_a - op_b;
      rv_pkg::ALU_AND: res = op_a & op_b;
      rv_pkg::ALU_OR:  res = op_a | op_b;
      rv_pkg::ALU_XOR: res = op_a ^ op_b;
      // Compare result is 0 or 1
      rv_pkg::ALU_SLT: res = {{(rv_pkg::XLEN-1){1'b0}}, lt_signed};
      rv_pkg::ALU_SLL: res = op_a << shamt;
      // Logical shift, zero fill
      rv_pkg::ALU_SRL: res = op_a >> shamt;
      default:         res = '0;
    endcase
  end

  // rd and illegal pass through untouched
  assign result_o.rd      = issue_i.rd;
  assign result_o.illegal = issue_i.illegal;
  // Illegal ops retire with a zero value
  assign result_o.value   = issue_i.illegal ? '0 : res;

endmodule

// File: logic/rv_stage_reg.sv
// One-entry pipeline register on a valid/ready stream
// Accepts new data in the same cycle its output is taken
`timescale 1ns/1ps

module rv_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     reset_i,

  // Upstream side
  input  logic     in_valid_i,
  input  payload_t in_data_i,
  output logic     in_ready_o,

  // Downstream side
  output logic     out_valid_o,
  output payload_t out_data_o,
  input  logic     out_ready_i
);

  logic     valid_q;
  payload_t data_q;

  // Room when empty or draining this cycle
  assign in_ready_o = !valid_q || out_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  // Payload only loads on an accepted transfer
  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;
    end
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

endmodule

// File: logic/rv_decode.sv
// Instruction decode with busy-bit scoreboard
// Splits the word, reads operands, stalls on busy registers, issues ops
`timescale 1ns/1ps

module rv_decode (
  input  logic                          clk_i,
  input  logic                          reset_i,

  // Instruction stream
  input  logic                          inst_valid_i,
  input  logic [31:0]                   inst_i,
  output logic                          inst_ready_o,

  // Register file read ports
  output logic [rv_pkg::REG_ADDR_W-1:0] raddr_a_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] raddr_b_o,
  input  logic [rv_pkg::XLEN-1:0]       rdata_a_i,
  input  logic [rv_pkg::XLEN-1:0]       rdata_b_i,

  // Issue stream toward execute
  output logic                          issue_valid_o,
  output rv_pkg::issue_t                issue_o,
  input  logic                          issue_ready_i,

  // Scoreboard release from retire
  input  logic                          free_valid_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] free_addr_i
);

  logic [6:0]                    opcode;
  logic [2:0]                    funct3;
  logic [6:0]                    funct7;
  logic [rv_pkg::REG_ADDR_W-1:0] rs1;
  logic [rv_pkg::REG_ADDR_W-1:0] rs2;
  logic [rv_pkg::REG_ADDR_W-1:0] rd;
  logic [rv_pkg::XLEN-1:0]       imm;
  logic                          is_op;
  logic                          is_op_imm;
  logic                          legal;
  rv_pkg::alu_op_e               alu_op;
  logic [rv_pkg::NUM_REGS-1:0]   busy_q;
  logic                          hazard;
  logic                          inst_hs;

  // Instruction fields
  assign opcode = inst_i[6:0];
  assign rd     = inst_i[11:7];
  assign funct3 = inst_i[14:12];
  assign rs1    = inst_i[19:15];
  assign rs2    = inst_i[24:20];
  assign funct7 = inst_i[31:25];
  // I-type immediate, sign extended from bit 31
  assign imm    = {{(rv_pkg::XLEN-12){inst_i[31]}}, inst_i[31:20]};

  assign is_op     = (opcode == rv_pkg::OPC_OP);
  assign is_op_imm = (opcode == rv_pkg::OPC_OP_IMM);

  // Opcode, funct3 and funct7 to ALU operation
  always_comb begin
    alu_op = rv_pkg::ALU_ADD;
    legal  = 1'b0;
    if (is_op) begin
      legal = 1'b1;
      case ({funct7, funct3})
        10'b0000000_000: alu_op = rv_pkg::ALU_ADD;
        10'b0100000_000: alu_op = rv_pkg::ALU_SUB;
        10'b0000000_001: alu_op = rv_pkg::ALU_SLL;
        10'b0000000_010: alu_op = rv_pkg::ALU_SLT;
        10'b0000000_100: alu_op = rv_pkg::ALU_XOR;
        10'b0000000_101: alu_op = rv_pkg::ALU_SRL;
        10'b0000000_110: alu_op = rv_pkg::ALU_OR;
        10'b0000000_111: alu_op = rv_pkg::ALU_AND;
        default:         legal  = 1'b0;
      endcase
    end else if (is_op_imm) begin
      // Shift-immediate and SLTIU are outside the subset
      legal = 1'b1;
      case (funct3)
        3'b000:  alu_op = rv_pkg::ALU_ADD;
        3'b010:  alu_op = rv_pkg::ALU_SLT;
        3'b100:  alu_op = rv_pkg::ALU_XOR;
        3'b110:  alu_op = rv_pkg::ALU_OR;
        3'b111:  alu_op = rv_pkg::ALU_AND;
        default: legal  = 1'b0;
      endcase
    end
  end

  // Source or destination still owned by an op in flight
  // rs2 only matters for R-type, illegal ops never touch registers
  assign hazard = legal && (busy_q[rs1] || (is_op && busy_q[rs2]) || busy_q[rd]);

  assign inst_ready_o  = issue_ready_i && !hazard;
  assign issue_valid_o = inst_valid_i && !hazard;
  assign inst_hs       = inst_valid_i && inst_ready_o;

  // Operand reads
  assign raddr_a_o = rs1;
  assign raddr_b_o = rs2;

  assign issue_o.alu_op  = alu_op;
  assign issue_o.op_a    = rdata_a_i;
  assign issue_o.op_b    = is_op ? rdata_b_i : imm;
  assign issue_o.rd      = rd;
  assign issue_o.illegal = !legal;

  // Scoreboard
  // Set on issue of a register write, cleared on its retire
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= '0;
    end else begin
      if (free_valid_i) begin
        busy_q[free_addr_i] <= 1'b0;
      end
      if (inst_hs && legal && (rd != '0)) begin
        busy_q[rd] <= 1'b1;
      end
    end
  end

endmodule

// File: logic/rv_regfile.sv
// Integer register file
// Two asynchronous read ports, one synchronous write port, x0 reads as zero
`timescale 1ns/1ps

module rv_regfile (
  input  logic                          clk_i,
  input  logic                          reset_i,

  // Read port A
  input  logic [rv_pkg::REG_ADDR_W-1:0] raddr_a_i,
  output logic [rv_pkg::XLEN-1:0]       rdata_a_o,
  // Read port B
  input  logic [rv_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [rv_pkg::XLEN-1:0]       rdata_b_o,

  // Write port
  input  logic [rv_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [rv_pkg::XLEN-1:0]       wdata_i,
  input  logic                          we_i
);

  logic [rv_pkg::XLEN-1:0] mem_q [rv_pkg::NUM_REGS];
  // Write enable with x0 masked off
  logic                    we_nz;

  assign we_nz = we_i && (waddr_i != '0);

  // Storage, cleared on reset so every entry starts at zero
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (we_nz) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // Asynchronous reads
  // x0 is forced to zero independent of the array contents
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : mem_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : mem_q[raddr_b_i];

endmodule

// File: logic/rv_pkg.sv
// Shared definitions for the RV32I subset pipeline
// Widths, opcode constants, ALU operation codes and stage payloads
package rv_pkg;

  // Datapath and register file geometry
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  // Major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // ALU operations, shared by R-type and I-type forms
  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4,
    ALU_SLT = 4'd5,
    ALU_SLL = 4'd6,
    ALU_SRL = 4'd7
  } alu_op_e;

  // Decode to execute payload
  typedef struct packed {
    alu_op_e               alu_op;
    logic [XLEN-1:0]       op_a;
    // Either rs2 data or the sign-extended immediate
    logic [XLEN-1:0]       op_b;
    logic [REG_ADDR_W-1:0] rd;
    logic                  illegal;
  } issue_t;

  // Execute to retire payload
  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       value;
    logic                  illegal;
  } exec_t;

  // Retired-result record at the core output
  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       value;
    logic                  illegal;
  } retire_t;

endpackage
